/* build.f */
+incdir+include
verilog/cache_axi_pkg.sv
verilog/arbiter_round_robin.sv
verilog/axi_converter.sv
verilog/axi_mem_slave.sv
verilog/cache_axi_subsys.sv
tests/cache_axi_checker.sv
tests/cache_axi_tb.sv

/* Bender.yml */
package:
  name: cache_axi

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/cache_axi_pkg.sv
      - verilog/arbiter_round_robin.sv
      - verilog/axi_converter.sv
      - verilog/axi_mem_slave.sv
      - verilog/cache_axi_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cache_axi_checker.sv
      - tests/cache_axi_tb.sv

/* tests/cache_axi_tb.sv */
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module cache_axi_tb
	import cache_axi_pkg::*;
();

	localparam int PORTS = `CACHE_PORT_NUM;
	localparam int NUM_TESTS = 12;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + RESET_CYCLES;

	typedef logic [`MEM_WORD_ADDR_BITS-1:0] word_idx_t;

	typedef struct packed {
		logic port;
		logic write;
		logic burst;
		addr_t addr;
		logic [3:0][31:0] data;
		strb_t strb;
		logic both;
	} test_entry_t;

	logic clk;
	logic rst_n;
	cache_bus_req_t [PORTS-1:0] req;
	cache_bus_resp_t [PORTS-1:0] resp;

	test_entry_t tests [NUM_TESTS];
	data_t shadow [1 << `MEM_WORD_ADDR_BITS];
	logic [PORTS-1:0] pending;
	int last_grant;
	int seed = 13;
	int errors = 0;
	int checks = 0;
	int cycle_cnt;

	cache_axi_subsys i_cache_axi_subsys (
		.clk   (clk),
		.rst_n (rst_n),
		.req_i (req),
		.resp_o(resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic test_entry_t make_test(input int port, input logic wr, input logic bst,
		input addr_t a, input data_t d0, input data_t d1, input data_t d2, input data_t d3,
		input strb_t strb, input logic both);
		test_entry_t e;
		e.port = port[0];
		e.write = wr;
		e.burst = bst;
		e.addr = a;
		e.data = {d3, d2, d1, d0};
		e.strb = strb;
		e.both = both;
		return e;
	endfunction

	// word hit by a beat, wrapping inside the aligned four-word block
	function automatic word_idx_t beat_word(input addr_t a, input int beat, input logic bst);
		word_idx_t w;
		w = a[`MEM_WORD_ADDR_BITS+1:2];
		if (bst) begin
			w = (w & ~word_idx_t'(3)) | ((w + word_idx_t'(beat)) & word_idx_t'(3));
		end
		return w;
	endfunction

	// first pending port after the last grant
	function automatic int next_grant(input logic [PORTS-1:0] pend, input int last);
		int idx;
		for (int off = 1; off <= PORTS; off++) begin
			idx = (last + off) % PORTS;
			if (pend[idx]) begin
				return idx;
			end
		end
		return -1;
	endfunction

	task automatic check_data(input string what, input data_t exp, input data_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_last(input string what, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic check_grant(input int exp_port, input int got_port);
		checks++;
		if (got_port != exp_port) begin
			errors++;
			$display("error at %0t: grant went to port %0d, expected port %0d", $time,
				got_port, exp_port);
		end
	endtask

	task automatic write_shadow(input word_idx_t w, input data_t d, input strb_t strb);
		for (int b = 0; b < `CACHE_BUS_DATA_LEN / 8; b++) begin
			if (strb[b]) begin
				shadow[w][8*b +: 8] = d[8*b +: 8];
			end
		end
	endtask

	// one full cache bus transaction, entered and left 2 ns after a rising edge
	task automatic run_request(input int p, input logic wr, input logic bst, input addr_t a,
		input logic [3:0][31:0] wdata, input strb_t strb);
		logic accepted;
		int beats;
		int beat;
		word_idx_t w;
		accepted = 1'b0;
		beats = bst ? 4 : 1;
		beat = 0;
		req[p].valid = 1'b1;
		req[p].write = wr;
		req[p].burst = bst;
		req[p].cached = 1'b1;
		req[p].addr = a;
		pending[p] = 1'b1;
		while (!accepted) begin
			@(negedge clk);
			if (resp[p].ready) begin
				accepted = 1'b1;
				check_grant(next_grant(pending, last_grant), p);
				last_grant = p;
				pending[p] = 1'b0;
			end
			@(posedge clk);
			#2;
		end
		req[p].valid = 1'b0;
		while (beat < beats) begin
			w = beat_word(a, beat, bst);
			if (wr) begin
				req[p].data_ok = 1'b1;
				req[p].w_data = wdata[beat];
				req[p].data_strobe = strb;
				req[p].data_last = (beat == beats - 1);
			end else begin
				// random back-pressure on reads
				req[p].data_ok = ($random(seed) & 3) != 0;
			end
			@(negedge clk);
			if (resp[p].data_ok) begin
				if (wr) begin
					write_shadow(w, wdata[beat], strb);
				end else begin
					check_data("read data", shadow[w], resp[p].r_data);
					check_last("data_last", beat == beats - 1, resp[p].data_last);
				end
				beat++;
			end
			@(posedge clk);
			#2;
		end
		req[p].data_last = 1'b0;
		if (!wr) begin
			// nothing may follow the last beat
			req[p].data_ok = 1'b1;
			@(negedge clk);
			check_last("beat after last", 1'b0, resp[p].data_ok);
			@(posedge clk);
			#2;
		end
		req[p].data_ok = 1'b0;
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run still busy after %0d cycles", cycle_cnt);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : main
		test_entry_t e;
		int err_before;
		req = '0;
		rst_n = 1'b0;
		pending = '0;
		last_grant = PORTS - 1;
		// contention pairs first, then single port traffic
		tests[0] = make_test(0, 1, 0, 32'h40, 32'h1111_0000, 0, 0, 0, 4'hf, 1);
		tests[1] = make_test(0, 1, 0, 32'h44, 32'h2222_0044, 0, 0, 0, 4'hf, 1);
		tests[2] = make_test(0, 1, 0, 32'h80, 32'ha5a5_0001, 0, 0, 0, 4'hf, 0);
		tests[3] = make_test(1, 0, 0, 32'h80, 0, 0, 0, 0, 4'h0, 0);
		tests[4] = make_test(1, 1, 1, 32'h104, 32'hb000_0001, 32'hb000_0002, 32'hb000_0003,
			32'hb000_0004, 4'hf, 0);
		tests[5] = make_test(0, 0, 1, 32'h108, 0, 0, 0, 0, 4'h0, 0);
		tests[6] = make_test(0, 1, 0, 32'h80, 32'h1234_5678, 0, 0, 0, 4'b0101, 0);
		tests[7] = make_test(1, 0, 0, 32'h80, 0, 0, 0, 0, 4'h0, 0);
		tests[8] = make_test(1, 0, 1, 32'h10c, 0, 0, 0, 0, 4'h0, 0);
		tests[9] = make_test(0, 0, 0, 32'h480, 0, 0, 0, 0, 4'h0, 0);
		tests[10] = make_test(1, 1, 0, 32'h12c4, 32'hc0de_00b1, 0, 0, 0, 4'hf, 0);
		tests[11] = make_test(0, 0, 0, 32'h2c4, 0, 0, 0, 0, 4'h0, 0);
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < NUM_TESTS; i++) begin
			e = tests[i];
			err_before = errors;
			if (e.both) begin
				// other port reads the same word at the same time
				fork
					run_request(int'(e.port), e.write, e.burst, e.addr, e.data, e.strb);
					run_request(1 - int'(e.port), 1'b0, 1'b0, e.addr, '0, '0);
				join
			end else begin
				run_request(int'(e.port), e.write, e.burst, e.addr, e.data, e.strb);
			end
			$display("test %0d port %0d %s %s addr %h: %s", i, e.port,
				e.write ? "write" : "read", e.burst ? "burst" : "single", e.addr,
				(errors == err_before) ? "passed" : "failed");
		end
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tests/cache_axi_checker.sv */
`timescale 1ns/1ps

module cache_axi_checker
	import cache_axi_pkg::*;
#(
	parameter int CACHE_PORT_NUM = 2
) (
	input logic                                clk,
	input logic                                rst_n,
	input cache_bus_resp_t [CACHE_PORT_NUM-1:0] resp_i,
	input axi_req_t                            axi_req_i,
	input axi_resp_t                           axi_resp_i
);

	logic [CACHE_PORT_NUM-1:0] ready_vec;

	always_comb begin
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			ready_vec[i] = resp_i[i].ready;
		end
	end

	// address valids stay up until the slave takes them
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axi_req_i.ar_valid && !axi_resp_i.ar_ready |=> axi_req_i.ar_valid)
		else $error("ar_valid dropped before ar_ready");

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axi_req_i.aw_valid && !axi_resp_i.aw_ready |=> axi_req_i.aw_valid)
		else $error("aw_valid dropped before aw_ready");

	ar_aw_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(axi_req_i.ar_valid && axi_req_i.aw_valid))
		else $error("ar_valid and aw_valid high together");

	// at most one port accepted per cycle
	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ready_vec))
		else $error("more than one cache port sees ready");

	// b_ready only follows the last accepted w beat
	b_after_write: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(axi_req_i.b_ready) |-> $past(axi_req_i.w_valid && axi_resp_i.w_ready
			&& axi_req_i.w.last))
		else $error("b_ready raised without a last write beat");

endmodule

bind axi_converter cache_axi_checker #(
	.CACHE_PORT_NUM(CACHE_PORT_NUM)
) i_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.resp_i    (resp_o),
	.axi_req_i (axi_req_o),
	.axi_resp_i(axi_resp_i)
);

/* verilog/cache_axi_subsys.sv */
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module cache_axi_subsys
	import cache_axi_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  cache_bus_req_t  [`CACHE_PORT_NUM-1:0] req_i,
	output cache_bus_resp_t [`CACHE_PORT_NUM-1:0] resp_o
);

	// single axi link between converter and memory
	axi_req_t axi_req;
	axi_resp_t axi_resp;

	axi_converter #(
		.CACHE_PORT_NUM(`CACHE_PORT_NUM)
	) i_converter (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_i     (req_i),
		.resp_o    (resp_o),
		.axi_req_o (axi_req),
		.axi_resp_i(axi_resp)
	);

	axi_mem_slave i_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.axi_req_i (axi_req),
		.axi_resp_o(axi_resp)
	);

endmodule

/* verilog/axi_mem_slave.sv */
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module axi_mem_slave
	import cache_axi_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  axi_req_t  axi_req_i,
	output axi_resp_t axi_resp_o
);

	localparam int MEM_WORDS = 1 << `MEM_WORD_ADDR_BITS;

	typedef logic [`MEM_WORD_ADDR_BITS-1:0] word_addr_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_READ,
		MEM_WRITE,
		MEM_BRESP
	} mem_state_e;

	mem_state_e state_q;
	mem_state_e state_d;

	data_t mem [MEM_WORDS];

	word_addr_t ar_word;
	word_addr_t aw_word;
	word_addr_t addr_q;
	word_addr_t addr_next;
	word_addr_t wrap_mask;
	axi_len_t len_q;
	axi_len_t beat_cnt_q;
	logic wrap_q;
	data_t r_data_q;

	logic ar_hs;
	logic aw_hs;
	logic r_hs;
	logic w_hs;
	logic b_hs;

	// upper address bits drop out, so big addresses alias modulo the depth
	assign ar_word = axi_req_i.ar.addr[`MEM_WORD_ADDR_BITS+1:2];
	assign aw_word = axi_req_i.aw.addr[`MEM_WORD_ADDR_BITS+1:2];

	assign axi_resp_o.ar_ready = (state_q == MEM_IDLE);
	// read wins if both arrive together
	assign axi_resp_o.aw_ready = (state_q == MEM_IDLE) & ~axi_req_i.ar_valid;
	assign axi_resp_o.w_ready = (state_q == MEM_WRITE);
	assign axi_resp_o.r_valid = (state_q == MEM_READ);
	assign axi_resp_o.r.data = r_data_q;
	assign axi_resp_o.r.resp = `AXI_RESP_OKAY;
	assign axi_resp_o.r.last = (beat_cnt_q == '0);
	assign axi_resp_o.b_valid = (state_q == MEM_BRESP);
	assign axi_resp_o.b_resp = `AXI_RESP_OKAY;

	assign ar_hs = axi_req_i.ar_valid & axi_resp_o.ar_ready;
	assign aw_hs = axi_req_i.aw_valid & axi_resp_o.aw_ready;
	assign r_hs = axi_resp_o.r_valid & axi_req_i.r_ready;
	assign w_hs = axi_req_i.w_valid & axi_resp_o.w_ready;
	assign b_hs = axi_resp_o.b_valid & axi_req_i.b_ready;

	// wrap keeps the upper bits and steps inside the len+1 word block
	assign wrap_mask = word_addr_t'(len_q);
	assign addr_next = wrap_q ? ((addr_q & ~wrap_mask) | ((addr_q + 1'b1) & wrap_mask))
		: (addr_q + 1'b1);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			MEM_IDLE: begin
				if (ar_hs) begin
					state_d = MEM_READ;
				end else if (aw_hs) begin
					state_d = MEM_WRITE;
				end
			end
			MEM_READ: if (r_hs && axi_resp_o.r.last) state_d = MEM_IDLE;
			MEM_WRITE: if (w_hs && axi_req_i.w.last) state_d = MEM_BRESP;
			MEM_BRESP: if (b_hs) state_d = MEM_IDLE;
			default: state_d = MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= MEM_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address, beat count and read data for the current burst
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			addr_q <= ar_word;
			len_q <= axi_req_i.ar.len;
			beat_cnt_q <= axi_req_i.ar.len;
			wrap_q <= (axi_req_i.ar.burst == `AXI_BURST_WRAP);
			r_data_q <= mem[ar_word];
		end else if (aw_hs) begin
			addr_q <= aw_word;
			len_q <= axi_req_i.aw.len;
			beat_cnt_q <= axi_req_i.aw.len;
			wrap_q <= (axi_req_i.aw.burst == `AXI_BURST_WRAP);
		end else if (r_hs || w_hs) begin
			addr_q <= addr_next;
			beat_cnt_q <= beat_cnt_q - 1'b1;
			if (r_hs) begin
				r_data_q <= mem[addr_next];
			end
		end
	end

	// byte lanes with their strobe set
	always_ff @(posedge clk) begin
		if (w_hs) begin
			for (int b = 0; b < `CACHE_BUS_DATA_LEN / 8; b++) begin
				if (axi_req_i.w.strb[b]) begin
					mem[addr_q][8*b +: 8] <= axi_req_i.w.data[8*b +: 8];
				end
			end
		end
	end

endmodule

/* verilog/axi_converter.sv */
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module axi_converter
	import cache_axi_pkg::*;
#(
	parameter int CACHE_PORT_NUM = `CACHE_PORT_NUM
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  cache_bus_req_t  [CACHE_PORT_NUM-1:0] req_i,
	output cache_bus_resp_t [CACHE_PORT_NUM-1:0] resp_o,
	output axi_req_t                            axi_req_o,
	input  axi_resp_t                           axi_resp_i
);

	conv_state_e state_q;
	conv_state_e state_d;

	logic take;
	logic in_data;
	logic [CACHE_PORT_NUM-1:0] req_valid;
	logic [CACHE_PORT_NUM-1:0] sel;
	logic [CACHE_PORT_NUM-1:0] grant_q;

	cache_bus_req_t new_req;
	cache_bus_req_t cur_req;

	// accepted request fields
	logic write_q;
	logic burst_q;
	logic cached_q;
	addr_t addr_q;

	axi_ar_t ax;
	logic ax_hs;
	logic r_hs;
	logic w_hs;
	logic b_hs;

	arbiter_round_robin #(
		.REQ_NUM(CACHE_PORT_NUM)
	) i_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_i     (req_valid),
		.take_sel_i(take),
		.sel_o     (sel)
	);

	assign take = (state_q == IDLE);
	assign in_data = (state_q == DATA);

	// pick the request being granted now and the one owning the data phase
	always_comb begin
		new_req = '0;
		cur_req = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			if (sel[i]) begin
				new_req = req_i[i];
			end
			if (grant_q[i]) begin
				cur_req = req_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			write_q <= new_req.write;
			burst_q <= new_req.burst;
			cached_q <= new_req.cached;
			addr_q <= new_req.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q <= '0;
		end else if (take && |sel) begin
			grant_q <= sel;
		end
	end

	// handshakes seen on the axi side
	assign ax_hs = write_q ? axi_resp_i.aw_ready : axi_resp_i.ar_ready;
	assign r_hs = axi_resp_i.r_valid & axi_req_o.r_ready;
	assign w_hs = axi_req_o.w_valid & axi_resp_i.w_ready;
	assign b_hs = axi_resp_i.b_valid & axi_req_o.b_ready;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: if (|sel) state_d = ADDR;
			ADDR: if (ax_hs) state_d = DATA;
			DATA: begin
				if (!write_q && r_hs && axi_resp_i.r.last) begin
					state_d = IDLE;
				end else if (write_q && w_hs && axi_req_o.w.last) begin
					state_d = RESP;
				end
			end
			RESP: if (b_hs) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// wrap bursts of full words, cached flag on the modifiable bit
	always_comb begin
		ax.addr = addr_q;
		ax.len = burst_q ? axi_len_t'(`AXI_BURST_LEN) : '0;
		ax.size = 3'($clog2(`CACHE_BUS_DATA_LEN / 8));
		ax.burst = `AXI_BURST_WRAP;
		ax.cache = {2'b00, cached_q, 1'b0};
		ax.prot = 3'b001;
	end

	always_comb begin
		axi_req_o.ar = ax;
		axi_req_o.ar_valid = (state_q == ADDR) & ~write_q;
		axi_req_o.aw = ax;
		axi_req_o.aw_valid = (state_q == ADDR) & write_q;
		axi_req_o.w.data = cur_req.w_data;
		axi_req_o.w.strb = cur_req.data_strobe;
		axi_req_o.w.last = cur_req.data_last;
		axi_req_o.w_valid = in_data & write_q & cur_req.data_ok;
		axi_req_o.r_ready = in_data & ~write_q & cur_req.data_ok;
		axi_req_o.b_ready = (state_q == RESP);
	end

	for (genvar i = 0; i < CACHE_PORT_NUM; i++) begin : g_port
		assign req_valid[i] = req_i[i].valid;
		assign resp_o[i].ready = sel[i] & take;
		// one beat per axi handshake, only toward the owner
		assign resp_o[i].data_ok = grant_q[i] & (w_hs | r_hs);
		assign resp_o[i].data_last = grant_q[i] & r_hs & axi_resp_i.r.last;
		assign resp_o[i].r_data = axi_resp_i.r.data;
	end

endmodule

/* verilog/arbiter_round_robin.sv */
`timescale 1ns/1ps

module arbiter_round_robin #(
	parameter int REQ_NUM = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [REQ_NUM-1:0] req_i,
	input  logic               take_sel_i,
	output logic [REQ_NUM-1:0] sel_o
);

	localparam int PTR_W = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

	logic [PTR_W-1:0] last_q;
	logic [PTR_W-1:0] sel_idx;

	// search starts one past the last grant and wraps around
	always_comb begin
		int unsigned idx;
		logic found;
		sel_o = '0;
		sel_idx = last_q;
		found = 1'b0;
		for (int off = 1; off <= REQ_NUM; off++) begin
			idx = (int'(last_q) + off) % REQ_NUM;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				sel_o[idx] = 1'b1;
				sel_idx = PTR_W'(idx);
			end
		end
	end

	// pointer on the top port after reset so port 0 wins first
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_q <= PTR_W'(REQ_NUM - 1);
		end else if (take_sel_i && |req_i) begin
			last_q <= sel_idx;
		end
	end

endmodule

/* verilog/cache_axi_pkg.sv */
`include "cache_axi_defines.svh"

package cache_axi_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [`CACHE_BUS_DATA_LEN-1:0] data_t;
	typedef logic [`CACHE_BUS_DATA_LEN/8-1:0] strb_t;
	typedef logic [7:0] axi_len_t;

	// requester side of the cache bus
	typedef struct packed {
		logic valid;
		logic write;
		logic burst;
		logic cached;
		addr_t addr;
		logic data_ok;
		logic data_last;
		strb_t data_strobe;
		data_t w_data;
	} cache_bus_req_t;

	// converter side of the cache bus
	typedef struct packed {
		logic ready;
		logic data_ok;
		logic data_last;
		data_t r_data;
	} cache_bus_resp_t;

	// address channel payload, same layout for ar and aw
	typedef struct packed {
		addr_t addr;
		axi_len_t len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [3:0] cache;
		logic [2:0] prot;
	} axi_ar_t;

	typedef axi_ar_t axi_aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		data_t data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	// master driven
	typedef struct packed {
		axi_ar_t ar;
		logic ar_valid;
		axi_aw_t aw;
		logic aw_valid;
		axi_w_t w;
		logic w_valid;
		logic r_ready;
		logic b_ready;
	} axi_req_t;

	// slave driven
	typedef struct packed {
		logic ar_ready;
		logic aw_ready;
		logic w_ready;
		axi_r_t r;
		logic r_valid;
		logic b_valid;
		logic [1:0] b_resp;
	} axi_resp_t;

	typedef enum logic [3:0] {
		IDLE = 4'b0001,
		ADDR = 4'b0010,
		DATA = 4'b0100,
		RESP = 4'b1000
	} conv_state_e;

endpackage

/* include/cache_axi_defines.svh */
`ifndef CACHE_AXI_DEFINES_SVH
`define CACHE_AXI_DEFINES_SVH

// cache ports sharing the one axi master
`define CACHE_PORT_NUM 2

// cache bus and axi data width in bits
`define CACHE_BUS_DATA_LEN 32

// axi len for a cache line burst, four beats
`define AXI_BURST_LEN 3

// memory depth as word address bits
`define MEM_WORD_ADDR_BITS 8

// axi encodings
`define AXI_BURST_WRAP 2'b10
`define AXI_RESP_OKAY 2'b00

`endif
